//--- reward_vga_top.f
+incdir+hw
hw/reward_pkg.sv
hw/vga_timing.sv
hw/reward_spawner.sv
hw/reward_sprite_rom.sv
hw/reward_display.sv
hw/reward_vga_top.sv
dv/reward_vga_checker.sv
dv/reward_vga_tb.sv

//--- run_sim.sh
#!/bin/sh
# builds the reward marker testbench with Verilator, runs it and scans the log for failure
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir build.log sim.log
verilator --binary --timing -Wno-fatal --top-module reward_vga_tb \
	-f reward_vga_top.f -o reward_vga_sim > build.log 2>&1 \
	|| { echo "verilator build failed, see build.log"; exit 1; }
./obj_dir/reward_vga_sim > sim.log 2>&1 \
	&& ! grep -q "SIMULATION FAILED" sim.log \
	|| { echo "simulation reported failure, see sim.log"; exit 1; }
echo "no failure found in sim.log"
exit 0

//--- dv/reward_vga_tb.sv
// reward vga testbench: clock, reset, random spawn, collect and enable stimulus, closing report
`timescale 1ns/1ps
`include "reward_defines.svh"

module reward_vga_tb;

	localparam int LINE_CYCLES = `H_VISIBLE + `H_FRONT + `H_SYNC + `H_BACK;
	localparam int FRAME_CYCLES = LINE_CYCLES * (`V_VISIBLE + `V_FRONT + `V_SYNC + `V_BACK);
	localparam int RUN_FRAMES = 3;
	localparam int TIMEOUT_CYCLES = RUN_FRAMES * FRAME_CYCLES + 16 * LINE_CYCLES; // 16 lines spare

	logic clk;
	logic reset;
	logic spawn;
	logic collect;
	logic display_enable;
	reward_pkg::pixel_t pixel;
	reward_pkg::cell_t reward_x;
	reward_pkg::cell_t reward_y;
	reward_pkg::reward_kind_t reward_kind;
	logic reward_active;

	int frames_done;
	int sync_errors;
	int pixel_errors;
	int reward_errors;
	int lit_pixels;
	int other_errors;
	int cycles;
	int line_pos; // position inside the current enable window
	int toggle_at;
	logic [31:0] lfsr_state;

	reward_vga_top reward_vga_top_i
	(
		.clk(clk),
		.reset(reset),
		.spawn(spawn),
		.collect(collect),
		.display_enable(display_enable),
		.pixel(pixel),
		.reward_x(reward_x),
		.reward_y(reward_y),
		.reward_kind(reward_kind),
		.reward_active(reward_active)
	);

	reward_vga_checker reward_vga_checker_i
	(
		.clk(clk),
		.reset(reset),
		.spawn(spawn),
		.collect(collect),
		.display_enable(display_enable),
		.pixel(pixel),
		.reward_x(reward_x),
		.reward_y(reward_y),
		.reward_kind(reward_kind),
		.reward_active(reward_active),
		.frames_done(frames_done),
		.sync_errors(sync_errors),
		.pixel_errors(pixel_errors),
		.reward_errors(reward_errors),
		.lit_pixels(lit_pixels)
	);

	initial
	begin
		clk = 1'b0;
		forever #10 clk = ~clk; // 20 ns period
	end

	// fibonacci lfsr, taps 32 22 2 1
	function automatic logic [31:0] lfsr_next(input logic [31:0] state);
		return {state[30:0], state[31] ^ state[21] ^ state[1] ^ state[0]};
	endfunction

	task automatic take_bits(input int count, output logic [31:0] bits);
		int i;
		bits = '0;
		for (i = 0; i < count; i++)
		begin
			lfsr_state = lfsr_next(lfsr_state); // one step per bit
			bits = {bits[30:0], lfsr_state[0]};
		end
	endtask

	task automatic drive_inputs();
		logic [31:0] bits;
		take_bits(10, bits);
		spawn = (bits[9:0] == 10'd0); // about once per 1024 cycles
		take_bits(12, bits);
		collect = (bits[11:0] == 12'd0);
		if (collect)
		begin
			take_bits(2, bits);
			if (bits[1:0] == 2'b00)
				spawn = 1'b1; // both strobes together now and then
		end
		if (line_pos == 0)
		begin
			take_bits(9, bits);
			toggle_at = int'(bits[8:0]);
		end
		if (line_pos == toggle_at)
			display_enable = !display_enable; // one toggle per line window
		line_pos = (line_pos == LINE_CYCLES - 1) ? 0 : line_pos + 1;
	endtask

	initial
	begin
		reset = 1'b1;
		spawn = 1'b0;
		collect = 1'b0;
		display_enable = 1'b1;
		lfsr_state = 32'h450c_cfd8;
		line_pos = 0;
		toggle_at = 0;
		cycles = 0;
		other_errors = 0;
		repeat (2) @(negedge clk);
		reset = 1'b0;
		while (frames_done < RUN_FRAMES && cycles < TIMEOUT_CYCLES)
		begin
			drive_inputs();
			@(negedge clk);
			cycles++;
		end
		spawn = 1'b0;
		collect = 1'b0;
		repeat (2) @(negedge clk); // drain the pixel pipeline
		if (frames_done < RUN_FRAMES)
		begin
			$display("ERROR: timeout after %0d cycles, only %0d of %0d frames checked",
				cycles, frames_done, RUN_FRAMES);
			other_errors++;
		end
		if (lit_pixels == 0)
		begin
			$display("ERROR: no reward pixel was drawn during the whole run");
			other_errors++;
		end
		$display("errors: sync %0d, pixel %0d, reward %0d, other %0d (%0d lit pixels checked)",
			sync_errors, pixel_errors, reward_errors, other_errors, lit_pixels);
		if (sync_errors + pixel_errors + reward_errors + other_errors == 0)
			$display("SIMULATION PASSED");
		else
			$display("SIMULATION FAILED");
		$finish;
	end

endmodule

//--- dv/reward_vga_checker.sv
// reward vga checker: models raster, reward strobes and sprite pixels and compares them with the DUT
`timescale 1ns/1ps
`include "reward_defines.svh"

module reward_vga_checker
(
	input logic clk,
	input logic reset,
	input logic spawn,
	input logic collect,
	input logic display_enable,
	input reward_pkg::pixel_t pixel,
	input reward_pkg::cell_t reward_x,
	input reward_pkg::cell_t reward_y,
	input reward_pkg::reward_kind_t reward_kind,
	input logic reward_active,
	output int frames_done,
	output int sync_errors,
	output int pixel_errors,
	output int reward_errors,
	output int lit_pixels
);

	localparam int H_TOTAL = `H_VISIBLE + `H_FRONT + `H_SYNC + `H_BACK;
	localparam int V_TOTAL = `V_VISIBLE + `V_FRONT + `V_SYNC + `V_BACK;
	localparam int H_SYNC_START = `H_VISIBLE + `H_FRONT;
	localparam int V_SYNC_START = `V_VISIBLE + `V_FRONT;
	localparam int PRINT_LIMIT = 40;

	// one raster position with the inputs and reward state seen along with it
	typedef struct packed {
		logic valid; // low while the pipeline still holds reset values
		reward_pkg::coord_t x;
		reward_pkg::coord_t y;
		logic enable;
		reward_pkg::cell_t rx;
		reward_pkg::cell_t ry;
		reward_pkg::reward_kind_t kind;
		logic active;
	} sample_t;

	sample_t hist_new; // taken one edge ago
	sample_t hist_old; // taken two edges ago, due at the pixel output now
	int mx;
	int my;
	int printed;
	logic first_cycle;
	logic prev_spawn;
	logic prev_collect;
	logic prev_active;
	reward_pkg::cell_t prev_x;
	reward_pkg::cell_t prev_y;
	reward_pkg::reward_kind_t prev_kind;

	function automatic logic sprite_bit(input reward_pkg::reward_kind_t kind, input int u,
		input int v);
		case (kind)
			reward_pkg::PROTECTED: return (u <= 1) || (u >= 22) || (v <= 1) || (v >= 22);
			reward_pkg::GRADE: return ((u >= 10) && (u <= 13)) || ((v >= 10) && (v <= 13));
			reward_pkg::SLOWLY: return (u == v) || (u + v == 23);
			default: return 1'b0;
		endcase
	endfunction

	function automatic reward_pkg::rgb_t kind_color(input reward_pkg::reward_kind_t kind);
		case (kind)
			reward_pkg::PROTECTED: return `COLOR_PROTECTED;
			reward_pkg::GRADE: return `COLOR_GRADE;
			reward_pkg::SLOWLY: return `COLOR_SLOWLY;
			default: return '0;
		endcase
	endfunction

	function automatic reward_pkg::pixel_t expected_pixel(input sample_t s);
		reward_pkg::pixel_t p;
		int u;
		int v;
		logic lit;
		p = '{rgb: '0, hsync: 1'b1, vsync: 1'b1}; // reset state of the output
		if (s.valid)
		begin
			p.hsync = !((s.x >= H_SYNC_START) && (s.x < H_SYNC_START + `H_SYNC));
			p.vsync = !((s.y >= V_SYNC_START) && (s.y < V_SYNC_START + `V_SYNC));
			u = int'(s.x) - int'(s.rx) * `CELL_SIZE + `SPRITE_HALF - 1;
			v = int'(s.y) - int'(s.ry) * `CELL_SIZE + `SPRITE_HALF - 1;
			lit = (s.x < `H_VISIBLE) && (s.y < `V_VISIBLE) && s.enable && s.active
				&& (u >= 0) && (u < `SPRITE_SIZE) && (v >= 0) && (v < `SPRITE_SIZE);
			if (lit && sprite_bit(s.kind, u, v))
				p.rgb = kind_color(s.kind);
		end
		return p;
	endfunction

	task automatic report_value(input string name, input logic [31:0] got,
		input logic [31:0] expected);
		if (printed < PRINT_LIMIT)
			$display("FAIL %s: got 0x%0h, expected 0x%0h (t=%0t)", name, got, expected, $time);
		else if (printed == PRINT_LIMIT)
			$display("more mismatches follow, they are counted but not printed");
		printed++;
	endtask

	// spawn and collect take effect one edge after the strobe
	task automatic check_reward_state();
		if (first_cycle)
		begin
			if (reward_active !== 1'b0)
			begin
				report_value("reward_active after reset", reward_active, 0);
				reward_errors++;
			end
			if (reward_kind !== reward_pkg::NONE)
			begin
				report_value("reward_kind after reset", reward_kind, reward_pkg::NONE);
				reward_errors++;
			end
		end
		else if (prev_spawn)
		begin
			if (reward_active !== 1'b1)
			begin
				report_value("reward_active after spawn", reward_active, 1);
				reward_errors++;
			end
			if (!(reward_x >= 1 && reward_x <= `CELL_X_MAX))
			begin
				report_value("reward_x out of 0x01..0x1f", reward_x, `CELL_X_MAX);
				reward_errors++;
			end
			if (!(reward_y >= 1 && reward_y <= `CELL_Y_MAX))
			begin
				report_value("reward_y out of 0x01..0x17", reward_y, `CELL_Y_MAX);
				reward_errors++;
			end
			if (reward_kind === reward_pkg::NONE || $isunknown(reward_kind))
			begin
				$display("FAIL reward_kind: got 0x%0h, expected a kind other than NONE",
					reward_kind);
				reward_errors++;
			end
		end
		else
		begin
			if (reward_active !== (prev_collect ? 1'b0 : prev_active))
			begin
				report_value("reward_active", reward_active, prev_collect ? 0 : prev_active);
				reward_errors++;
			end
			if (reward_x !== prev_x || reward_y !== prev_y || reward_kind !== prev_kind)
			begin
				report_value("reward cell and kind without spawn",
					{reward_x, reward_y, reward_kind}, {prev_x, prev_y, prev_kind});
				reward_errors++;
			end
		end
	endtask

	always @(posedge clk)
	begin : check_cycle
		reward_pkg::pixel_t expect_pixel;
		sample_t now;
		if (reset)
		begin
			mx = 0;
			my = 0;
			hist_new = '0;
			hist_old = '0;
			first_cycle = 1'b1;
		end
		else
		begin
			expect_pixel = expected_pixel(hist_old);
			if (pixel.hsync !== expect_pixel.hsync || pixel.vsync !== expect_pixel.vsync)
			begin
				report_value($sformatf("pixel.hsync/vsync at x=%0d y=%0d", hist_old.x,
					hist_old.y), {pixel.hsync, pixel.vsync},
					{expect_pixel.hsync, expect_pixel.vsync});
				sync_errors++;
			end
			if (pixel.rgb !== expect_pixel.rgb)
			begin
				report_value($sformatf("pixel.rgb at x=%0d y=%0d", hist_old.x, hist_old.y),
					pixel.rgb, expect_pixel.rgb);
				pixel_errors++;
			end
			if (expect_pixel.rgb != '0)
				lit_pixels++;
			check_reward_state();

			now.valid = 1'b1;
			now.x = reward_pkg::coord_t'(mx);
			now.y = reward_pkg::coord_t'(my);
			now.enable = display_enable;
			now.rx = reward_x;
			now.ry = reward_y;
			now.kind = reward_kind;
			now.active = reward_active;
			hist_old = hist_new;
			hist_new = now;

			prev_spawn = spawn;
			prev_collect = collect;
			prev_active = reward_active;
			prev_x = reward_x;
			prev_y = reward_y;
			prev_kind = reward_kind;
			first_cycle = 1'b0;

			if (mx == H_TOTAL - 1)
			begin
				mx = 0;
				if (my == V_TOTAL - 1)
				begin
					my = 0;
					frames_done++; // a whole frame has passed the model
				end
				else
					my++;
			end
			else
				mx++;
		end
	end

endmodule

//--- hw/reward_vga_top.sv
// reward vga top: timing, spawner and display with syncs aligned to the pixel pipeline
`timescale 1ns/1ps

module reward_vga_top
(
	input logic clk,
	input logic reset,
	input logic spawn,
	input logic collect,
	input logic display_enable,
	output reward_pkg::pixel_t pixel,
	output reward_pkg::cell_t reward_x,
	output reward_pkg::cell_t reward_y,
	output reward_pkg::reward_kind_t reward_kind,
	output logic reward_active
);

	reward_pkg::raster_t raster;
	reward_pkg::rgb_t rgb;
	logic [1:0] hsync_d; // [1] is the older sample
	logic [1:0] vsync_d;

	vga_timing vga_timing_i
	(
		.clk(clk),
		.reset(reset),
		.raster(raster)
	);

	reward_spawner reward_spawner_i
	(
		.clk(clk),
		.reset(reset),
		.spawn(spawn),
		.collect(collect),
		.reward_x(reward_x),
		.reward_y(reward_y),
		.reward_kind(reward_kind),
		.reward_active(reward_active)
	);

	reward_display reward_display_i
	(
		.clk(clk),
		.reset(reset),
		.raster(raster),
		.display_enable(display_enable),
		.reward_x(reward_x),
		.reward_y(reward_y),
		.reward_kind(reward_kind),
		.reward_active(reward_active),
		.rgb(rgb)
	);

	// matches the two cycle latency of the display
	always_ff @(posedge clk)
	begin
		if (reset)
		begin
			hsync_d <= 2'b11;
			vsync_d <= 2'b11;
		end
		else
		begin
			hsync_d <= {hsync_d[0], raster.hsync};
			vsync_d <= {vsync_d[0], raster.vsync};
		end
	end

	assign pixel = '{rgb: rgb, hsync: hsync_d[1], vsync: vsync_d[1]};

endmodule

//--- hw/reward_display.sv
// reward display: two-stage pipeline from raster position to reward colour
`timescale 1ns/1ps
`include "reward_defines.svh"

module reward_display
(
	input logic clk,
	input logic reset,
	input reward_pkg::raster_t raster,
	input logic display_enable,
	input reward_pkg::cell_t reward_x,
	input reward_pkg::cell_t reward_y,
	input reward_pkg::reward_kind_t reward_kind,
	input logic reward_active,
	output reward_pkg::rgb_t rgb
);

	reward_pkg::coord_t cx;
	reward_pkg::coord_t cy;
	reward_pkg::coord_t u;
	reward_pkg::coord_t v;
	reward_pkg::sprite_addr_t rom_addr;
	logic in_window;
	logic hit;
	logic hit_q;
	reward_pkg::reward_kind_t kind_q;
	logic rom_bit;
	reward_pkg::rgb_t kind_color;

	// stage 1: window test and rom address
	assign cx = reward_pkg::coord_t'(reward_x) * reward_pkg::coord_t'(`CELL_SIZE);
	assign cy = reward_pkg::coord_t'(reward_y) * reward_pkg::coord_t'(`CELL_SIZE);
	assign u = raster.x + reward_pkg::coord_t'(`SPRITE_HALF - 1) - cx; // wraps when left of window
	assign v = raster.y + reward_pkg::coord_t'(`SPRITE_HALF - 1) - cy;
	assign in_window = (u < reward_pkg::coord_t'(`SPRITE_SIZE))
		&& (v < reward_pkg::coord_t'(`SPRITE_SIZE));
	assign hit = raster.visible && display_enable && reward_active && in_window;
	assign rom_addr = reward_pkg::sprite_addr_t'(u + v * reward_pkg::coord_t'(`SPRITE_SIZE));

	reward_sprite_rom reward_sprite_rom_i
	(
		.clk(clk),
		.addr(rom_addr),
		.kind(reward_kind),
		.bit_out(rom_bit)
	);

	always_ff @(posedge clk)
	begin
		if (reset)
			hit_q <= 1'b0;
		else
			hit_q <= hit;
	end

	always_ff @(posedge clk)
	begin
		kind_q <= reward_kind; // travels alongside the rom read
	end

	always_comb
	begin
		case (kind_q)
			reward_pkg::PROTECTED: kind_color = `COLOR_PROTECTED;
			reward_pkg::GRADE: kind_color = `COLOR_GRADE;
			reward_pkg::SLOWLY: kind_color = `COLOR_SLOWLY;
			default: kind_color = '0;
		endcase
	end

	// stage 2: colour out
	always_ff @(posedge clk)
	begin
		if (reset)
			rgb <= '0;
		else if (hit_q && rom_bit)
			rgb <= kind_color;
		else
			rgb <= '0;
	end

endmodule

//--- hw/reward_sprite_rom.sv
// reward sprite rom: synchronous 24x24 one-bit bitmaps for the three reward kinds
`timescale 1ns/1ps
`include "reward_defines.svh"

module reward_sprite_rom
(
	input logic clk,
	input reward_pkg::sprite_addr_t addr,
	input reward_pkg::reward_kind_t kind,
	output logic bit_out
);

	localparam int SIZE = `SPRITE_SIZE;
	localparam int DEPTH = SIZE * SIZE;

	// evaluates the geometric rule of one kind over the whole sprite
	function automatic logic [DEPTH-1:0] build_map(input reward_pkg::reward_kind_t map_kind);
		logic [DEPTH-1:0] map;
		int u;
		int v;
		logic on;
		map = '0;
		for (v = 0; v < SIZE; v++)
		begin
			for (u = 0; u < SIZE; u++)
			begin
				case (map_kind)
					reward_pkg::PROTECTED: on = (u < 2) || (u >= SIZE - 2)
						|| (v < 2) || (v >= SIZE - 2); // two pixel frame
					reward_pkg::GRADE: on = ((u >= `SPRITE_HALF - 2) && (u <= `SPRITE_HALF + 1))
						|| ((v >= `SPRITE_HALF - 2) && (v <= `SPRITE_HALF + 1));
					reward_pkg::SLOWLY: on = (u == v) || (u + v == SIZE - 1);
					default: on = 1'b0;
				endcase
				map[u + SIZE * v] = on;
			end
		end
		return map;
	endfunction

	localparam logic [DEPTH-1:0] MAP_PROTECTED = build_map(reward_pkg::PROTECTED);
	localparam logic [DEPTH-1:0] MAP_GRADE = build_map(reward_pkg::GRADE);
	localparam logic [DEPTH-1:0] MAP_SLOWLY = build_map(reward_pkg::SLOWLY);

	logic in_range;

	assign in_range = (addr < reward_pkg::sprite_addr_t'(DEPTH));

	always_ff @(posedge clk)
	begin
		if (!in_range)
			bit_out <= 1'b0; // address outside the sprite
		else
		begin
			case (kind)
				reward_pkg::PROTECTED: bit_out <= MAP_PROTECTED[addr];
				reward_pkg::GRADE: bit_out <= MAP_GRADE[addr];
				reward_pkg::SLOWLY: bit_out <= MAP_SLOWLY[addr];
				default: bit_out <= 1'b0;
			endcase
		end
	end

endmodule

//--- hw/reward_spawner.sv
// reward spawner: places a reward at a pseudo-random cell with a random kind, clears on collect
`timescale 1ns/1ps
`include "reward_defines.svh"

module reward_spawner
(
	input logic clk,
	input logic reset,
	input logic spawn,
	input logic collect,
	output reward_pkg::cell_t reward_x,
	output reward_pkg::cell_t reward_y,
	output reward_pkg::reward_kind_t reward_kind,
	output logic reward_active
);

	logic [15:0] lfsr;
	logic feedback;
	logic [4:0] raw_x;
	logic [4:0] raw_y;
	reward_pkg::cell_t next_x;
	reward_pkg::cell_t next_y;
	reward_pkg::reward_kind_t next_kind;

	assign feedback = lfsr[15] ^ lfsr[13] ^ lfsr[12] ^ lfsr[10]; // taps 16,14,13,11
	assign raw_x = lfsr[4:0];
	assign raw_y = lfsr[9:5];

	always_comb
	begin
		next_x = (raw_x == 5'd0) ? reward_pkg::cell_t'(1) : reward_pkg::cell_t'(raw_x);
		if (raw_y == 5'd0)
			next_y = reward_pkg::cell_t'(1);
		else if (raw_y > 5'(`CELL_Y_MAX))
			next_y = reward_pkg::cell_t'(raw_y - 5'd16); // fold rows below the grid upward
		else
			next_y = reward_pkg::cell_t'(raw_y);
		next_kind = reward_pkg::reward_kind_t'(lfsr[11:10]);
		if (next_kind == reward_pkg::NONE)
			next_kind = reward_pkg::PROTECTED;
	end

	always_ff @(posedge clk)
	begin
		if (reset)
		begin
			lfsr <= `SPAWN_SEED;
			reward_x <= reward_pkg::cell_t'(1);
			reward_y <= reward_pkg::cell_t'(1);
			reward_kind <= reward_pkg::NONE;
			reward_active <= 1'b0;
		end
		else
		begin
			lfsr <= {lfsr[14:0], feedback}; // steps every cycle
			if (spawn)
			begin
				reward_x <= next_x;
				reward_y <= next_y;
				reward_kind <= next_kind;
				reward_active <= 1'b1; // spawn wins over collect
			end
			else if (collect)
				reward_active <= 1'b0;
		end
	end

endmodule

//--- hw/vga_timing.sv
// vga timing generator: free-running pixel and line counters with registered syncs
`timescale 1ns/1ps
`include "reward_defines.svh"

module vga_timing
(
	input logic clk,
	input logic reset,
	output reward_pkg::raster_t raster
);

	localparam int H_TOTAL = `H_VISIBLE + `H_FRONT + `H_SYNC + `H_BACK;
	localparam int V_TOTAL = `V_VISIBLE + `V_FRONT + `V_SYNC + `V_BACK;
	localparam int H_SYNC_START = `H_VISIBLE + `H_FRONT;
	localparam int V_SYNC_START = `V_VISIBLE + `V_FRONT;

	reward_pkg::coord_t x_next;
	reward_pkg::coord_t y_next;
	logic line_end;

	assign line_end = (raster.x == reward_pkg::coord_t'(H_TOTAL - 1));

	always_comb
	begin
		x_next = line_end ? '0 : raster.x + 1'b1;
		y_next = raster.y;
		if (line_end)
		begin
			if (raster.y == reward_pkg::coord_t'(V_TOTAL - 1))
				y_next = '0; // wrap to the top of the next frame
			else
				y_next = raster.y + 1'b1;
		end
	end

	// flags are derived from the next position so they line up with x and y
	always_ff @(posedge clk)
	begin
		if (reset)
		begin
			raster.x <= '0;
			raster.y <= '0;
			raster.visible <= 1'b1;
			raster.hsync <= 1'b1;
			raster.vsync <= 1'b1;
		end
		else
		begin
			raster.x <= x_next;
			raster.y <= y_next;
			raster.visible <= (x_next < reward_pkg::coord_t'(`H_VISIBLE))
				&& (y_next < reward_pkg::coord_t'(`V_VISIBLE));
			raster.hsync <= !((x_next >= reward_pkg::coord_t'(H_SYNC_START))
				&& (x_next < reward_pkg::coord_t'(H_SYNC_START + `H_SYNC)));
			raster.vsync <= !((y_next >= reward_pkg::coord_t'(V_SYNC_START))
				&& (y_next < reward_pkg::coord_t'(V_SYNC_START + `V_SYNC)));
		end
	end

endmodule

//--- hw/reward_pkg.sv
// reward marker types: coordinates, grid cells, reward kinds, raster and pixel bundles
package reward_pkg;

	typedef logic [10:0] coord_t; // pixel coordinate, covers the full 800x525 frame
	typedef logic [5:0] cell_t; // grid index
	typedef logic [11:0] rgb_t; // 4:4:4 colour
	typedef logic [9:0] sprite_addr_t; // u + 24*v

	typedef enum logic [1:0] {
		NONE,
		PROTECTED,
		GRADE,
		SLOWLY
	} reward_kind_t;

	typedef struct packed {
		coord_t x;
		coord_t y;
		logic visible;
		logic hsync; // active low
		logic vsync; // active low
	} raster_t;

	typedef struct packed {
		rgb_t rgb;
		logic hsync;
		logic vsync;
	} pixel_t;

endpackage

//--- hw/reward_defines.svh
// reward marker defines: raster layout, grid pitch, sprite size and reward colours
`ifndef REWARD_DEFINES_SVH
`define REWARD_DEFINES_SVH

`define H_VISIBLE 640 // active pixels per line
`define H_FRONT 16
`define H_SYNC 96
`define H_BACK 48

`define V_VISIBLE 480 // active lines per frame
`define V_FRONT 10
`define V_SYNC 2
`define V_BACK 33

`define CELL_SIZE 20 // grid pitch in pixels
`define SPRITE_SIZE 24
`define SPRITE_HALF 12
`define CELL_X_MAX 31 // smallest legal index is 1 on both axes
`define CELL_Y_MAX 23

`define COLOR_PROTECTED 12'h0FF
`define COLOR_GRADE 12'hFF0
`define COLOR_SLOWLY 12'h00F

`define SPAWN_SEED 16'hACE1 // any nonzero value

`endif
